// ==== logic/vsldu_settings.svh ====
//////////////////////////////////////////////////
// Geometry and width macros for the slide unit
// Include before the package and in every module
//////////////////////////////////////////////////

`ifndef VSLDU_SETTINGS_SVH
`define VSLDU_SETTINGS_SVH

// VRF word and register shape
`define VSLDU_VRF_WORD_BYTES 8
`define VSLDU_BYTE_IDX_W 3
`define VSLDU_NR_VREGS 32
`define VSLDU_WORDS_PER_VREG 4
`define VSLDU_WORD_IDX_W 2
`define VSLDU_MAXVL_BYTES (`VSLDU_VRF_WORD_BYTES * `VSLDU_WORDS_PER_VREG)

// Field widths
`define VSLDU_VLEN_W 8
`define VSLDU_ID_W 3
`define VSLDU_ELEN 32

`endif

// ==== logic/vsldu_pkg.sv ====
//////////////////////////////////////////////////
// Shared types of the slide unit, referred to
// by scoped names from the modules
//////////////////////////////////////////////////

`default_nettype none

`include "vsldu_settings.svh"

package vsldu_pkg;

  typedef enum logic {
    OP_SLIDE_UP   = 1'b0,
    OP_SLIDE_DOWN = 1'b1
  } sld_op_e;

  // Element width code, also the byte shift
  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } vsew_e;

  typedef logic [$clog2(`VSLDU_NR_VREGS)-1:0] vreg_idx_t;
  typedef logic [$clog2(`VSLDU_NR_VREGS)+`VSLDU_WORD_IDX_W-1:0] vrf_addr_t;
  typedef logic [8*`VSLDU_VRF_WORD_BYTES-1:0] vrf_data_t;
  typedef logic [`VSLDU_VRF_WORD_BYTES-1:0] vrf_be_t;
  typedef logic [`VSLDU_VLEN_W-1:0] vlen_t;
  typedef logic [`VSLDU_ID_W-1:0] sld_id_t;

  // Request as seen on the port, counts in elements
  typedef struct packed {
    sld_op_e                 op;
    vsew_e                   vsew;
    vlen_t                   vl;
    vlen_t                   vstart;
    logic [`VSLDU_ELEN-1:0]  amount;
    vreg_idx_t               vs2;
    vreg_idx_t               vd;
    sld_id_t                 id;
  } sld_req_t;

  typedef struct packed {
    vrf_addr_t waddr;
    vrf_data_t wdata;
    vrf_be_t   wbe;
  } vrf_wreq_t;

endpackage

`default_nettype wire

// ==== logic/vsldu_spill_reg.sv ====
//////////////////////////////////////////////////
// Two-entry valid/ready register for any payload
// Shows the oldest entry and the waiting one
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vsldu_settings.svh"

module vsldu_spill_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic reset_i,
  input  T     data_i,
  input  logic valid_i,
  output logic ready_o,
  output T     data_o,
  output logic valid_o,
  output T     data_queue_o,
  output logic valid_queue_o,
  input  logic ready_i
);

  T     head_q, tail_q;
  logic head_full_q, tail_full_q;
  logic push, pop;

  assign ready_o       = !tail_full_q;
  assign data_o        = head_q;
  assign valid_o       = head_full_q;
  assign data_queue_o  = tail_q;
  assign valid_queue_o = tail_full_q;

  assign push = valid_i && ready_o;
  assign pop  = head_full_q && ready_i;

  // Slot flags
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      head_full_q <= 1'b0;
      tail_full_q <= 1'b0;
    end else if (pop) begin
      head_full_q <= tail_full_q || push;
      tail_full_q <= tail_full_q && push;
    end else if (push) begin
      head_full_q <= 1'b1;
      tail_full_q <= head_full_q;
    end
  end

  // Payload moves forward on pop, new data fills the first free slot
  always_ff @(posedge clk_i) begin
    if (pop) begin
      if (tail_full_q) begin
        head_q <= tail_q;
        if (push) tail_q <= data_i;
      end else if (push) begin
        head_q <= data_i;
      end
    end else if (push) begin
      if (head_full_q) tail_q <= data_i;
      else head_q <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== logic/vsldu_ctrl.sv ====
//////////////////////////////////////////////////
// Slide control: byte counter, read and write
// addresses and the completion response
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vsldu_settings.svh"

module vsldu_ctrl (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  vsldu_pkg::sld_req_t   req_i,
  input  logic                  req_valid_i,
  input  vsldu_pkg::sld_req_t   cur_req_i,
  input  logic                  cur_valid_i,
  input  vsldu_pkg::sld_req_t   queue_req_i,
  input  logic                  queue_valid_i,
  input  logic                  vrf_rvalid_i,
  input  logic                  wreq_ready_i,
  input  logic                  vrf_wvalid_i,
  output logic                  done_o,
  output vsldu_pkg::vlen_t      offset_o,
  output vsldu_pkg::vlen_t      offset_next_o,
  output vsldu_pkg::vlen_t      counter_o,
  output vsldu_pkg::vlen_t      delta_o,
  output logic                  first_o,
  output logic                  last_o,
  output logic                  advance_o,
  output logic                  prefetch_o,
  output logic                  finished_o,
  output vsldu_pkg::vrf_addr_t  vrf_raddr_o,
  output logic                  vrf_re_o,
  output logic                  wreq_valid_o,
  output vsldu_pkg::vrf_addr_t  waddr_o,
  output logic                  rsp_valid_o,
  output vsldu_pkg::sld_id_t    rsp_id_o
);

  localparam int BW = `VSLDU_BYTE_IDX_W;
  localparam int VW = `VSLDU_VLEN_W;

  typedef enum logic {
    RSP_RUNNING,
    RSP_WAIT_ACK
  } rsp_state_e;

  vsldu_pkg::sld_req_t     init_req;
  logic [`VSLDU_ELEN+1:0]  amount_wide;
  vsldu_pkg::vlen_t        init_vl, init_vstart, init_amount;
  vsldu_pkg::vlen_t        vl_q, offset_q, offset_d, counter_q, counter_d;
  vsldu_pkg::vlen_t        remaining, word_room, delta;
  vsldu_pkg::vrf_addr_t    rd_word, wr_word, amount_word;
  vsldu_pkg::sld_id_t      id_q;
  rsp_state_e              state_q;
  logic                    new_req, is_up, prefetch_q, first_q;
  logic                    last, advance, finished, hold, rsp_fire;
  logic [1:0]              wcnt_q;
  logic                    wpop, pos_q;

  //////////////////////////////////////////////////
  // Request normalisation, elements to bytes
  //////////////////////////////////////////////////

  always_comb begin
    // The waiting entry is always older than the port
    init_req    = queue_valid_i ? queue_req_i : req_i;
    init_vl     = init_req.vl << init_req.vsew;
    init_vstart = init_req.vstart << init_req.vsew;
    amount_wide = {2'b00, init_req.amount} << init_req.vsew;
    init_amount = (amount_wide > `VSLDU_MAXVL_BYTES) ? VW'(`VSLDU_MAXVL_BYTES)
                                                     : amount_wide[VW-1:0];
  end

  assign new_req  = done_o && (queue_valid_i || req_valid_i);
  assign offset_d = new_req ? init_amount : offset_q;

  //////////////////////////////////////////////////
  // Byte counter and word flags
  //////////////////////////////////////////////////

  assign is_up     = cur_req_i.op == vsldu_pkg::OP_SLIDE_UP;
  assign remaining = vl_q - counter_q;
  assign word_room = VW'(`VSLDU_VRF_WORD_BYTES) - {{(VW-BW){1'b0}}, counter_q[BW-1:0]};
  assign last      = cur_valid_i && !prefetch_q && (remaining <= word_room);
  assign delta     = last ? remaining : word_room;

  // A second last write waits until the pending response goes out
  assign rsp_fire = (state_q == RSP_WAIT_ACK) && wpop && !pos_q;
  assign hold     = last && (state_q == RSP_WAIT_ACK) && !rsp_fire;

  assign vrf_re_o     = cur_valid_i && (prefetch_q || (wreq_ready_i && !hold));
  assign wreq_valid_o = vrf_re_o && vrf_rvalid_i && !prefetch_q;
  assign advance      = wreq_valid_o && wreq_ready_i;
  assign finished     = last && advance;
  assign done_o       = !cur_valid_i || finished;

  always_comb begin
    counter_d = counter_q;
    if (new_req) begin
      // Slide-up never writes below the amount
      if (init_req.op == vsldu_pkg::OP_SLIDE_UP && init_vstart < init_amount)
        counter_d = init_amount;
      else
        counter_d = init_vstart;
    end else if (advance) begin
      counter_d = counter_q + delta;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      vl_q       <= '0;
      offset_q   <= '0;
      counter_q  <= '0;
      prefetch_q <= 1'b0;
      first_q    <= 1'b0;
    end else begin
      offset_q  <= offset_d;
      counter_q <= counter_d;
      if (new_req) begin
        vl_q       <= init_vl;
        first_q    <= 1'b1;
        prefetch_q <= (init_req.op == vsldu_pkg::OP_SLIDE_UP) ?
                      (init_vstart >= VW'(`VSLDU_VRF_WORD_BYTES)) : 1'b1;
      end else begin
        if (prefetch_q && vrf_re_o && vrf_rvalid_i) prefetch_q <= 1'b0;
        if (advance) first_q <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Address generation
  //////////////////////////////////////////////////

  always_comb begin
    wr_word     = vsldu_pkg::vrf_addr_t'(counter_q[VW-1:BW]);
    amount_word = vsldu_pkg::vrf_addr_t'(offset_q[VW-1:BW]);
    // Down reads ahead of the write word, up reads behind it
    if (is_up)
      rd_word = wr_word - amount_word - vsldu_pkg::vrf_addr_t'(prefetch_q);
    else
      rd_word = wr_word + amount_word + vsldu_pkg::vrf_addr_t'(!prefetch_q);
    vrf_raddr_o = {cur_req_i.vs2, `VSLDU_WORD_IDX_W'(0)} + rd_word;
    waddr_o     = {cur_req_i.vd, `VSLDU_WORD_IDX_W'(0)} + wr_word;
  end

  //////////////////////////////////////////////////
  // Completion response
  //////////////////////////////////////////////////

  // Entries held in the write register
  assign wpop = vrf_wvalid_i && (wcnt_q != 2'd0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= RSP_RUNNING;
      wcnt_q  <= 2'd0;
      pos_q   <= 1'b0;
      id_q    <= '0;
    end else begin
      wcnt_q <= wcnt_q + {1'b0, advance} - {1'b0, wpop};
      if (finished) begin
        state_q <= RSP_WAIT_ACK;
        id_q    <= cur_req_i.id;
        // Writes still ahead of this last one
        pos_q   <= (wcnt_q - {1'b0, wpop}) != 2'd0;
      end else if (state_q == RSP_WAIT_ACK && wpop) begin
        if (pos_q) pos_q <= 1'b0;
        else state_q <= RSP_RUNNING;
      end
    end
  end

  assign rsp_valid_o = rsp_fire;
  assign rsp_id_o    = id_q;

  assign offset_o      = offset_q;
  assign offset_next_o = offset_d;
  assign counter_o     = counter_q;
  assign delta_o       = delta;
  assign first_o       = first_q && cur_valid_i && !prefetch_q;
  assign last_o        = last;
  assign advance_o     = advance;
  assign prefetch_o    = prefetch_q;
  assign finished_o    = finished;

endmodule

`default_nettype wire

// ==== logic/vsldu_shifter.sv ====
//////////////////////////////////////////////////
// Byte slider: splits each read word at the slide
// offset and merges it with the overflow of the last
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vsldu_settings.svh"

module vsldu_shifter (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  vsldu_pkg::sld_op_e   op_i,
  input  vsldu_pkg::vlen_t     offset_i,
  input  vsldu_pkg::vlen_t     offset_next_i,
  input  vsldu_pkg::vlen_t     counter_i,
  input  vsldu_pkg::vlen_t     delta_i,
  input  logic                 first_i,
  input  logic                 last_i,
  input  logic                 advance_i,
  input  logic                 prefetch_i,
  input  logic                 finished_i,
  input  vsldu_pkg::vrf_data_t rdata_i,
  output vsldu_pkg::vrf_data_t wdata_o,
  output vsldu_pkg::vrf_be_t   wbe_o
);

  localparam int NB = `VSLDU_VRF_WORD_BYTES;
  localparam int BW = `VSLDU_BYTE_IDX_W;
  localparam int VW = `VSLDU_VLEN_W;

  vsldu_pkg::vrf_data_t flipped, data_in, data_high, data_low, data_out, out_flip;
  vsldu_pkg::vrf_data_t overflow_q;
  logic [BW-1:0]        off_q;
  logic [BW:0]          flip_q;
  logic [VW-BW:0]       rd_word;
  logic                 is_up;

  // In-word offsets, registered one cycle ahead of use
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      off_q  <= '0;
      flip_q <= (BW+1)'(NB);
    end else begin
      off_q  <= offset_next_i[BW-1:0];
      flip_q <= (BW+1)'(NB) - {1'b0, offset_next_i[BW-1:0]};
    end
  end

  always_comb begin
    is_up   = op_i == vsldu_pkg::OP_SLIDE_UP;
    rd_word = {1'b0, counter_i[VW-1:BW]} + {1'b0, offset_i[VW-1:BW]}
              + {{(VW-BW){1'b0}}, !prefetch_i};

    // Slide-up runs as a slide-down on the mirrored word
    for (int b = 0; b < NB; b++)
      flipped[(NB-1-b)*8 +: 8] = rdata_i[b*8 +: 8];
    data_in = is_up ? flipped : rdata_i;

    // Source words past MAXVL read as zero
    if (!is_up && rd_word >= `VSLDU_WORDS_PER_VREG)
      data_in = '0;

    data_high = data_in >> (8 * off_q);
    data_low  = data_in << (8 * flip_q);
    data_out  = (is_up ? data_high : data_low) | overflow_q;

    for (int b = 0; b < NB; b++)
      out_flip[(NB-1-b)*8 +: 8] = data_out[b*8 +: 8];
    wdata_o = is_up ? out_flip : data_out;
  end

  // Byte enables
  always_comb begin
    for (int i = 0; i < NB; i++) begin
      wbe_o[i] = (i >= counter_i[BW-1:0]) &&
                 (!last_i || i < (int'(counter_i[BW-1:0]) + int'(delta_i)));
      // First up word holds nothing below the slide offset
      if (first_i && is_up && counter_i[VW-1:BW] == offset_i[VW-1:BW] &&
          i < offset_i[BW-1:0])
        wbe_o[i] = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      overflow_q <= '0;
    end else if (finished_i) begin
      overflow_q <= '0;
    end else if (advance_i || prefetch_i) begin
      overflow_q <= is_up ? data_low : data_high;
    end
  end

endmodule

`default_nettype wire

// ==== logic/vsldu_top.sv ====
//////////////////////////////////////////////////
// Vector slide unit top: request queue, control,
// shifter and VRF write register
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vsldu_settings.svh"

module vsldu_top (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  vsldu_pkg::sld_req_t   req_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  output logic                  rsp_valid_o,
  output vsldu_pkg::sld_id_t    rsp_id_o,
  output vsldu_pkg::vrf_addr_t  vrf_raddr_o,
  output logic                  vrf_re_o,
  input  vsldu_pkg::vrf_data_t  vrf_rdata_i,
  input  logic                  vrf_rvalid_i,
  output vsldu_pkg::vrf_addr_t  vrf_waddr_o,
  output vsldu_pkg::vrf_data_t  vrf_wdata_o,
  output vsldu_pkg::vrf_be_t    vrf_wbe_o,
  output logic                  vrf_we_o,
  input  logic                  vrf_wvalid_i
);

  vsldu_pkg::sld_req_t  cur_req, queue_req;
  logic                 cur_valid, queue_valid, done;
  vsldu_pkg::vlen_t     offset, offset_next, counter, delta;
  logic                 first, last, advance, prefetch, finished;
  vsldu_pkg::vrf_addr_t waddr;
  vsldu_pkg::vrf_data_t wdata;
  vsldu_pkg::vrf_be_t   wbe;
  vsldu_pkg::vrf_wreq_t wreq, wreq_q;
  logic                 wreq_valid, wreq_ready;

  //////////////////////////////////////////////////
  // Request queue
  //////////////////////////////////////////////////

  vsldu_spill_reg #(.T(vsldu_pkg::sld_req_t)) i_req_queue (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .data_i        (req_i),
    .valid_i       (req_valid_i),
    .ready_o       (req_ready_o),
    .data_o        (cur_req),
    .valid_o       (cur_valid),
    .data_queue_o  (queue_req),
    .valid_queue_o (queue_valid),
    .ready_i       (done)
  );

  vsldu_ctrl i_ctrl (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .cur_req_i     (cur_req),
    .cur_valid_i   (cur_valid),
    .queue_req_i   (queue_req),
    .queue_valid_i (queue_valid),
    .vrf_rvalid_i  (vrf_rvalid_i),
    .wreq_ready_i  (wreq_ready),
    .vrf_wvalid_i  (vrf_wvalid_i),
    .done_o        (done),
    .offset_o      (offset),
    .offset_next_o (offset_next),
    .counter_o     (counter),
    .delta_o       (delta),
    .first_o       (first),
    .last_o        (last),
    .advance_o     (advance),
    .prefetch_o    (prefetch),
    .finished_o    (finished),
    .vrf_raddr_o   (vrf_raddr_o),
    .vrf_re_o      (vrf_re_o),
    .wreq_valid_o  (wreq_valid),
    .waddr_o       (waddr),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_id_o      (rsp_id_o)
  );

  vsldu_shifter i_shifter (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .op_i          (cur_req.op),
    .offset_i      (offset),
    .offset_next_i (offset_next),
    .counter_i     (counter),
    .delta_i       (delta),
    .first_i       (first),
    .last_i        (last),
    .advance_i     (advance),
    .prefetch_i    (prefetch),
    .finished_i    (finished),
    .rdata_i       (vrf_rdata_i),
    .wdata_o       (wdata),
    .wbe_o         (wbe)
  );

  //////////////////////////////////////////////////
  // VRF write register
  //////////////////////////////////////////////////

  assign wreq.waddr = waddr;
  assign wreq.wdata = wdata;
  assign wreq.wbe   = wbe;

  vsldu_spill_reg #(.T(vsldu_pkg::vrf_wreq_t)) i_wreq_reg (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .data_i        (wreq),
    .valid_i       (wreq_valid),
    .ready_o       (wreq_ready),
    .data_o        (wreq_q),
    .valid_o       (vrf_we_o),
    .data_queue_o  (),
    .valid_queue_o (),
    .ready_i       (vrf_wvalid_i)
  );

  assign vrf_waddr_o = wreq_q.waddr;
  assign vrf_wdata_o = wreq_q.wdata;
  assign vrf_wbe_o   = wreq_q.wbe;

endmodule

`default_nettype wire

// ==== sim/vsldu_clkgen.sv ====
//////////////////////////////////////////////////
// Testbench clock and synchronous reset source
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vsldu_clkgen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset drops on a falling edge, away from the sampling edge
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

`default_nettype wire

// ==== sim/vrf_model.sv ====
//////////////////////////////////////////////////
// Behavioural VRF with stall inputs for reads and
// writes; contents are loaded by the testbench
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vsldu_settings.svh"

module vrf_model (
  input  logic                 clk_i,
  input  logic                 rstall_i,
  input  logic                 wstall_i,
  input  vsldu_pkg::vrf_addr_t raddr_i,
  input  logic                 re_i,
  output vsldu_pkg::vrf_data_t rdata_o,
  output logic                 rvalid_o,
  input  vsldu_pkg::vrf_addr_t waddr_i,
  input  vsldu_pkg::vrf_data_t wdata_i,
  input  vsldu_pkg::vrf_be_t   wbe_i,
  input  logic                 we_i,
  output logic                 wvalid_o
);

  localparam int NB    = `VSLDU_VRF_WORD_BYTES;
  localparam int WORDS = `VSLDU_NR_VREGS * `VSLDU_WORDS_PER_VREG;

  vsldu_pkg::vrf_data_t mem [0:WORDS-1];

  // Both ports answer in the same cycle unless stalled
  assign rdata_o  = mem[raddr_i];
  assign rvalid_o = re_i && !rstall_i;
  assign wvalid_o = we_i && !wstall_i;

  always @(posedge clk_i) begin
    if (we_i && wvalid_o) begin
      for (int b = 0; b < NB; b++) begin
        if (wbe_i[b])
          mem[waddr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
      end
    end
  end

endmodule

`default_nettype wire

// ==== sim/vsldu_tb.sv ====
//////////////////////////////////////////////////
// Directed tests of the slide unit against a byte
// level reference of slide-up and slide-down
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vsldu_settings.svh"

module vsldu_tb;

  localparam int NB          = `VSLDU_VRF_WORD_BYTES;
  localparam int WORDS       = `VSLDU_WORDS_PER_VREG;
  localparam int MAXVL       = `VSLDU_MAXVL_BYTES;
  localparam int TEST_CYCLES = 200;
  localparam int WATCHDOG    = 20 * TEST_CYCLES;
  localparam int WAIT_LIMIT  = 150;
  localparam vsldu_pkg::sld_op_e UP   = vsldu_pkg::OP_SLIDE_UP;
  localparam vsldu_pkg::sld_op_e DOWN = vsldu_pkg::OP_SLIDE_DOWN;
  localparam vsldu_pkg::vsew_e   E8   = vsldu_pkg::EW_8;
  localparam vsldu_pkg::vsew_e   E16  = vsldu_pkg::EW_16;
  localparam vsldu_pkg::vsew_e   E32  = vsldu_pkg::EW_32;

  logic                 clk, reset;
  vsldu_pkg::sld_req_t  req;
  logic                 req_valid, req_ready, rsp_valid;
  vsldu_pkg::sld_id_t   rsp_id;
  vsldu_pkg::vrf_addr_t vrf_raddr, vrf_waddr;
  vsldu_pkg::vrf_data_t vrf_rdata, vrf_wdata;
  vsldu_pkg::vrf_be_t   vrf_wbe;
  logic                 vrf_re, vrf_rvalid, vrf_we, vrf_wvalid;
  logic                 rstall, wstall, stall_en;

  integer     seed = 4440;
  int         errors, tests_run, tests_failed;
  int         rsp_ids [$];
  logic [7:0] expect_mem [0:1][0:MAXVL-1];

  vsldu_clkgen #(.PERIOD_NS(20), .RESET_CYCLES(16)) i_clkgen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  vrf_model i_vrf (
    .clk_i    (clk),
    .rstall_i (rstall),
    .wstall_i (wstall),
    .raddr_i  (vrf_raddr),
    .re_i     (vrf_re),
    .rdata_o  (vrf_rdata),
    .rvalid_o (vrf_rvalid),
    .waddr_i  (vrf_waddr),
    .wdata_i  (vrf_wdata),
    .wbe_i    (vrf_wbe),
    .we_i     (vrf_we),
    .wvalid_o (vrf_wvalid)
  );

  vsldu_top UUT (
    .clk_i        (clk),
    .reset_i      (reset),
    .req_i        (req),
    .req_valid_i  (req_valid),
    .req_ready_o  (req_ready),
    .rsp_valid_o  (rsp_valid),
    .rsp_id_o     (rsp_id),
    .vrf_raddr_o  (vrf_raddr),
    .vrf_re_o     (vrf_re),
    .vrf_rdata_i  (vrf_rdata),
    .vrf_rvalid_i (vrf_rvalid),
    .vrf_waddr_o  (vrf_waddr),
    .vrf_wdata_o  (vrf_wdata),
    .vrf_wbe_o    (vrf_wbe),
    .vrf_we_o     (vrf_we),
    .vrf_wvalid_i (vrf_wvalid)
  );

  //////////////////////////////////////////////////
  // Stall pattern and response monitor
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (stall_en) begin
      rstall = ($random(seed) & 3) == 0;
      wstall = ($random(seed) & 3) == 0;
    end else begin
      rstall = 1'b0;
      wstall = 1'b0;
    end
  end

  always @(posedge clk) begin
    if (!reset && rsp_valid)
      rsp_ids.push_back(int'(rsp_id));
  end

  initial begin
    repeat (WATCHDOG) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG);
    $display("Simulation FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic vsldu_pkg::sld_req_t make_req(
    input vsldu_pkg::sld_op_e op, input vsldu_pkg::vsew_e vsew, input int vl,
    input int vstart, input int amount, input int vs2, input int vd, input int id);
    vsldu_pkg::sld_req_t r;
    r.op     = op;
    r.vsew   = vsew;
    r.vl     = vsldu_pkg::vlen_t'(vl);
    r.vstart = vsldu_pkg::vlen_t'(vstart);
    r.amount = amount;
    r.vs2    = vsldu_pkg::vreg_idx_t'(vs2);
    r.vd     = vsldu_pkg::vreg_idx_t'(vd);
    r.id     = vsldu_pkg::sld_id_t'(id);
    return r;
  endfunction

  function automatic logic [7:0] vrf_byte(input int r, input int b);
    return i_vrf.mem[r * WORDS + b / NB][(b % NB) * 8 +: 8];
  endfunction

  task automatic refill(input int r);
    for (int w = 0; w < WORDS; w++)
      i_vrf.mem[r * WORDS + w] = {$random(seed), $random(seed)};
  endtask

  // Reference in elements, then spread over the element's bytes
  task automatic build_expect(input int slot, input vsldu_pkg::sld_req_t r);
    int esz, nel, amt, src;
    esz = 1 << int'(r.vsew);
    nel = MAXVL / esz;
    amt = int'(r.amount);
    for (int b = 0; b < MAXVL; b++)
      expect_mem[slot][b] = vrf_byte(r.vd, b);
    for (int i = int'(r.vstart); i < int'(r.vl); i++) begin
      for (int k = 0; k < esz; k++) begin
        if (r.op == DOWN) begin
          src = i + amt;
          expect_mem[slot][i*esz+k] = (src < nel) ? vrf_byte(r.vs2, src*esz+k) : 8'h00;
        end else if (i >= amt) begin
          expect_mem[slot][i*esz+k] = vrf_byte(r.vs2, (i-amt)*esz+k);
        end
      end
    end
  endtask

  task automatic send(input vsldu_pkg::sld_req_t r);
    int waited;
    waited = 0;
    req = r;
    req_valid = 1'b1;
    while (!req_ready && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!req_ready) begin
      $display("Request with id %0d was never accepted", r.id);
      errors++;
    end
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic collect(input int n);
    int waited;
    waited = 0;
    while (rsp_ids.size() < n && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (rsp_ids.size() < n) begin
      $display("Only %0d of %0d responses arrived in time", rsp_ids.size(), n);
      errors++;
    end
    // Idle a while so a repeated response shows up
    repeat (8) @(negedge clk);
    if (rsp_ids.size() > n) begin
      $display("Got %0d responses for %0d requests", rsp_ids.size(), n);
      errors++;
    end
  endtask

  task automatic check_id(input int idx, input vsldu_pkg::sld_req_t r);
    if (rsp_ids.size() > idx && rsp_ids[idx] != int'(r.id)) begin
      $display("Fail at %0t: rsp_id_o got %0d expected %0d", $time, rsp_ids[idx], r.id);
      errors++;
    end
  endtask

  task automatic check_bytes(input int slot, input vsldu_pkg::sld_req_t r);
    logic [7:0] got;
    for (int b = 0; b < MAXVL; b++) begin
      got = vrf_byte(r.vd, b);
      if (got !== expect_mem[slot][b]) begin
        $display("Fail at %0t: vrf v%0d byte %0d got %02h expected %02h",
                 $time, r.vd, b, got, expect_mem[slot][b]);
        errors++;
      end
    end
  endtask

  task automatic report(input string name, input int errs_at_start);
    tests_run++;
    if (errors == errs_at_start) begin
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", name, errors - errs_at_start);
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic run_one(input string name, input vsldu_pkg::sld_req_t r);
    int errs_at_start;
    errs_at_start = errors;
    refill(r.vs2);
    refill(r.vd);
    build_expect(0, r);
    rsp_ids.delete();
    send(r);
    collect(1);
    check_id(0, r);
    check_bytes(0, r);
    report(name, errs_at_start);
  endtask

  // Second request waits in the queue while the first runs
  task automatic run_pair(input string name, input vsldu_pkg::sld_req_t ra,
                          input vsldu_pkg::sld_req_t rb);
    int errs_at_start;
    errs_at_start = errors;
    refill(ra.vs2);
    refill(ra.vd);
    refill(rb.vs2);
    refill(rb.vd);
    build_expect(0, ra);
    build_expect(1, rb);
    rsp_ids.delete();
    send(ra);
    send(rb);
    collect(2);
    check_id(0, ra);
    check_id(1, rb);
    check_bytes(0, ra);
    check_bytes(1, rb);
    report(name, errs_at_start);
  endtask

  initial begin
    req          = '0;
    req_valid    = 1'b0;
    rstall       = 1'b0;
    wstall       = 1'b0;
    stall_en     = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int a = 0; a < `VSLDU_NR_VREGS; a++)
      refill(a);
    @(negedge clk);
    while (reset) @(negedge clk);

    run_one("down e8 amount 0", make_req(DOWN, E8, 32, 0, 0, 2, 3, 1));
    run_one("down e8 amount 3", make_req(DOWN, E8, 32, 0, 3, 4, 5, 2));
    run_one("down e8 amount 9", make_req(DOWN, E8, 32, 0, 9, 6, 7, 3));
    run_one("up e16 amount 3", make_req(UP, E16, 16, 0, 3, 8, 9, 4));
    run_one("up e32 amount 1", make_req(UP, E32, 8, 0, 1, 10, 11, 5));
    run_one("up e32 amount 5", make_req(UP, E32, 8, 0, 5, 12, 13, 6));
    run_one("down e8 vstart 5", make_req(DOWN, E8, 32, 5, 2, 14, 15, 7));
    run_one("down e16 vstart 6", make_req(DOWN, E16, 16, 6, 3, 16, 17, 0));
    run_one("up e8 vstart 11", make_req(UP, E8, 32, 11, 4, 18, 19, 1));
    run_one("up e16 vstart 2", make_req(UP, E16, 16, 2, 1, 20, 21, 2));
    run_one("down e8 vl 13", make_req(DOWN, E8, 13, 0, 2, 22, 23, 3));
    run_one("up e32 vl 5", make_req(UP, E32, 5, 0, 2, 24, 25, 4));
    run_one("down e16 vl 7", make_req(DOWN, E16, 7, 1, 4, 26, 27, 5));
    run_pair("back to back", make_req(DOWN, E8, 32, 0, 5, 28, 29, 6),
             make_req(UP, E16, 14, 0, 2, 30, 31, 7));

    // Same checks with random VRF stalls
    stall_en = 1'b1;
    run_one("stall down e32", make_req(DOWN, E32, 8, 0, 3, 1, 0, 0));
    run_one("stall up e8", make_req(UP, E8, 27, 9, 6, 2, 5, 1));
    run_pair("stall back to back", make_req(DOWN, E16, 16, 3, 2, 3, 4, 2),
             make_req(UP, E8, 32, 0, 10, 6, 7, 3));
    stall_en = 1'b0;

    $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+logic
logic/vsldu_pkg.sv
logic/vsldu_spill_reg.sv
logic/vsldu_ctrl.sv
logic/vsldu_shifter.sv
logic/vsldu_top.sv
sim/vsldu_clkgen.sv
sim/vrf_model.sv
sim/vsldu_tb.sv

// ==== Bender.yml ====
package:
  name: vsldu

export_include_dirs:
  - logic

sources:
  - logic/vsldu_pkg.sv
  - logic/vsldu_spill_reg.sv
  - logic/vsldu_ctrl.sv
  - logic/vsldu_shifter.sv
  - logic/vsldu_top.sv
  - target: simulation
    files:
      - sim/vsldu_clkgen.sv
      - sim/vrf_model.sv
      - sim/vsldu_tb.sv
